//--- source/mips_pkg.sv
// shared encodings and constants for the multicycle mips cpu, referenced by scope from every file
`default_nettype none

package mips_pkg;

  localparam logic [31:0] reset_vector = 32'hbfc0_0000; // first fetch after reset
  localparam logic [4:0]  link_reg     = 5'd31;         // ra, written by jal and the al branches

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    op_special = 6'd0,
    op_regimm  = 6'd1,  // bltz/bgez family, selected by b code
    op_j       = 6'd2,
    op_jal     = 6'd3,
    op_beq     = 6'd4,
    op_bne     = 6'd5,
    op_blez    = 6'd6,
    op_bgtz    = 6'd7,
    op_addiu   = 6'd9,
    op_slti    = 6'd10,
    op_sltiu   = 6'd11,
    op_andi    = 6'd12,
    op_ori     = 6'd13,
    op_xori    = 6'd14,
    op_lui     = 6'd15,
    op_lb      = 6'd32,
    op_lh      = 6'd33,
    op_lw      = 6'd35,
    op_lbu     = 6'd36,
    op_lhu     = 6'd37,
    op_sb      = 6'd40,
    op_sh      = 6'd41,
    op_sw      = 6'd43
  } opcode_t;

  // special function codes, instr[5:0]
  typedef enum logic [5:0] {
    fn_sll   = 6'd0,  fn_srl   = 6'd2,  fn_sra  = 6'd3,
    fn_sllv  = 6'd4,  fn_srlv  = 6'd6,  fn_srav = 6'd7,
    fn_jr    = 6'd8,  fn_jalr  = 6'd9,
    fn_mfhi  = 6'd16, fn_mthi  = 6'd17, fn_mflo = 6'd18, fn_mtlo = 6'd19,
    fn_mult  = 6'd24, fn_multu = 6'd25,
    fn_add   = 6'd32, fn_addu  = 6'd33, fn_sub  = 6'd34, fn_subu = 6'd35,  // no overflow traps
    fn_and   = 6'd36, fn_or    = 6'd37, fn_xor  = 6'd38, fn_nor  = 6'd39,
    fn_slt   = 6'd42, fn_sltu  = 6'd43
  } funct_t;

  // regimm b codes, instr[20:16]
  typedef enum logic [4:0] {
    rt_bltz   = 5'd0,
    rt_bgez   = 5'd1,
    rt_bltzal = 5'd16,
    rt_bgezal = 5'd17
  } regimm_t;

  typedef enum logic [1:0] {
    st_fetch = 2'd0,  // instruction read, holds on waitrequest
    st_load  = 2'd1,  // decode and register read
    st_mem   = 2'd2,  // data access, holds on waitrequest
    st_exec  = 2'd3   // writeback and pc update
  } cpu_state_t;

  // alu operation classes
  typedef enum logic [1:0] {
    alu_addr   = 2'd0,  // base plus offset
    alu_branch = 2'd1,  // subtract for beq/bne compare
    alu_rtype  = 2'd2,  // op from function code
    alu_itype  = 2'd3   // op from opcode
  } alu_op_t;

endpackage

`default_nettype wire

//--- source/control.sv
// combinational decoder turning the cpu state and instruction fields into bus and datapath controls
`timescale 1ns/1ps
`default_nettype none

module control (
  input  logic                 reset,
  input  logic [5:0]           opcode,           // instr[31:26]
  input  logic [5:0]           function_code,    // instr[5:0]
  input  logic [4:0]           b_code,           // instr[20:16]
  input  mips_pkg::cpu_state_t state,
  input  logic [1:0]           byte_addressing,  // low bits of the data address
  output logic                 read,
  output logic                 write,
  output logic [2:0]           write_data_sel,   // 0 word, 1-4 byte lane 0-3, 5-6 low/high half
  output logic [3:0]           byteenable,
  output logic [1:0]           rd_select,        // 0 rt, 1 rd, 2 ra
  output logic                 reg_write_enable,
  output logic [2:0]           datamem_to_reg,   // 0 alu, 1 lw, 2 lb, 3 lbu, 4 lh, 5 lhu
  output logic                 link_to_reg,
  output logic                 mfhi,
  output logic                 mflo,
  output logic                 hi_wren,
  output logic                 lo_wren,
  output logic                 multdiv,
  output logic                 imdt_sel,         // zero extend for andi, ori, xori
  output logic                 alu_src,          // 1 picks the immediate
  output mips_pkg::alu_op_t    alu_op,
  output logic                 branch,
  output logic                 jump,
  output logic                 jumpreg
);

  always_comb begin
    // idle defaults; alu_addr with the immediate is the address calculation
    read             = 1'b0;
    write            = 1'b0;
    write_data_sel   = 3'd0;
    byteenable       = 4'b1111;
    rd_select        = 2'd0;
    reg_write_enable = 1'b0;
    datamem_to_reg   = 3'd0;
    link_to_reg      = 1'b0;
    mfhi             = 1'b0;
    mflo             = 1'b0;
    hi_wren          = 1'b0;
    lo_wren          = 1'b0;
    multdiv          = 1'b0;
    imdt_sel         = 1'b0;
    alu_src          = 1'b1;
    alu_op           = mips_pkg::alu_addr;
    branch           = 1'b0;
    jump             = 1'b0;
    jumpreg          = 1'b0;

    case (state)
      mips_pkg::st_fetch: read = 1'b1;  // word at pc

      // load only decodes, instruction already latched so bus stays idle

      mips_pkg::st_mem: begin
        case (opcode)
          mips_pkg::op_sb: begin
            write          = 1'b1;
            byteenable     = 4'b0001 << byte_addressing;    // one lane
            write_data_sel = {1'b0, byte_addressing} + 3'd1;
          end
          mips_pkg::op_sh: begin
            write          = 1'b1;
            byteenable     = byte_addressing[1] ? 4'b1100 : 4'b0011;
            write_data_sel = byte_addressing[1] ? 3'd6 : 3'd5;
          end
          mips_pkg::op_sw: write = 1'b1;
          mips_pkg::op_lb, mips_pkg::op_lh, mips_pkg::op_lw,
          mips_pkg::op_lbu, mips_pkg::op_lhu: read = 1'b1;
          default: ;  // no access, mem passes in one cycle
        endcase
      end

      mips_pkg::st_exec: begin
        case (opcode)
          mips_pkg::op_special: begin
            rd_select = 2'd1;
            alu_src   = 1'b0;
            alu_op    = mips_pkg::alu_rtype;
            case (function_code)
              mips_pkg::fn_jr:   jumpreg = 1'b1;
              mips_pkg::fn_jalr: begin
                jumpreg          = 1'b1;
                link_to_reg      = 1'b1;
                reg_write_enable = 1'b1;
              end
              mips_pkg::fn_mthi: hi_wren = 1'b1;
              mips_pkg::fn_mtlo: lo_wren = 1'b1;
              mips_pkg::fn_mult, mips_pkg::fn_multu: begin
                multdiv = 1'b1;   // product fills both halves
                hi_wren = 1'b1;
                lo_wren = 1'b1;
              end
              mips_pkg::fn_mfhi: begin
                mfhi             = 1'b1;
                reg_write_enable = 1'b1;
              end
              mips_pkg::fn_mflo: begin
                mflo             = 1'b1;
                reg_write_enable = 1'b1;
              end
              default: reg_write_enable = 1'b1;  // alu r-type into rd
            endcase
          end
          mips_pkg::op_regimm: begin
            branch = 1'b1;
            if (b_code == mips_pkg::rt_bltzal || b_code == mips_pkg::rt_bgezal) begin
              rd_select        = 2'd2;  // link written taken or not
              link_to_reg      = 1'b1;
              reg_write_enable = 1'b1;
            end
          end
          mips_pkg::op_j:   jump = 1'b1;
          mips_pkg::op_jal: begin
            jump             = 1'b1;
            rd_select        = 2'd2;
            link_to_reg      = 1'b1;
            reg_write_enable = 1'b1;
          end
          mips_pkg::op_beq, mips_pkg::op_bne: begin
            branch  = 1'b1;
            alu_src = 1'b0;
            alu_op  = mips_pkg::alu_branch;  // zero flag compares rs and rt
          end
          mips_pkg::op_blez, mips_pkg::op_bgtz: branch = 1'b1;
          mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu, mips_pkg::op_lui: begin
            alu_op           = mips_pkg::alu_itype;
            reg_write_enable = 1'b1;
          end
          mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori: begin
            alu_op           = mips_pkg::alu_itype;
            imdt_sel         = 1'b1;
            reg_write_enable = 1'b1;
          end
          // loads keep alu_addr so the low address bits pick the lane again
          mips_pkg::op_lw: begin
            datamem_to_reg   = 3'd1;
            reg_write_enable = 1'b1;
          end
          mips_pkg::op_lb: begin
            datamem_to_reg   = 3'd2;
            reg_write_enable = 1'b1;
          end
          mips_pkg::op_lbu: begin
            datamem_to_reg   = 3'd3;
            reg_write_enable = 1'b1;
          end
          mips_pkg::op_lh: begin
            datamem_to_reg   = 3'd4;
            reg_write_enable = 1'b1;
          end
          mips_pkg::op_lhu: begin
            datamem_to_reg   = 3'd5;
            reg_write_enable = 1'b1;
          end
          default: ;  // stores finished in mem
        endcase
      end

      default: ;
    endcase
  end

  // no opcode and state pair may drive both strobes
  always_comb begin
    if (!reset) begin
      assert (!(read && write)) else $error("control: read and write both high");
    end
  end

endmodule

`default_nettype wire

//--- source/register_file.sv
// 32 x 32-bit general purpose registers, two async read ports and one write port for the cpu
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  read_reg_a,   // rs
  input  logic [4:0]  read_reg_b,   // rt
  input  logic [4:0]  write_reg,
  input  logic [31:0] write_data,
  input  logic        write_enable, // exec edge only
  output logic [31:0] read_data_a,
  output logic [31:0] read_data_b,
  output logic [31:0] register_v0   // r2 tap for the testbench
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (write_enable && write_reg != 5'd0) begin  // r0 never written
      regs[write_reg] <= write_data;
    end
  end

  assign read_data_a = regs[read_reg_a];
  assign read_data_b = regs[read_reg_b];
  assign register_v0 = regs[2];

  // holds across every writeback, including ones aimed at r0
  a_r0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == 32'd0)
    else $error("register_file: r0 not zero");

endmodule

`default_nettype wire

//--- source/alu.sv
// 32-bit alu for the cpu: picks the operation from the alu_op class and function or opcode
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  mips_pkg::alu_op_t alu_op,
  input  logic [5:0]        function_code,
  input  logic [5:0]        opcode,
  input  logic [4:0]        shamt,
  input  logic [31:0]       a,       // rs
  input  logic [31:0]       b,       // rt or extended immediate
  output logic [31:0]       result,
  output logic              zero
);

  always_comb begin
    result = 32'd0;
    case (alu_op)
      mips_pkg::alu_addr:   result = a + b;   // load/store address, also default class
      mips_pkg::alu_branch: result = a - b;   // zero when equal
      mips_pkg::alu_rtype: begin
        case (function_code)
          mips_pkg::fn_sll:  result = b << shamt;
          mips_pkg::fn_srl:  result = b >> shamt;
          mips_pkg::fn_sra:  result = $signed(b) >>> shamt;
          mips_pkg::fn_sllv: result = b << a[4:0];  // amount from rs
          mips_pkg::fn_srlv: result = b >> a[4:0];
          mips_pkg::fn_srav: result = $signed(b) >>> a[4:0];
          mips_pkg::fn_add, mips_pkg::fn_addu: result = a + b;
          mips_pkg::fn_sub, mips_pkg::fn_subu: result = a - b;
          mips_pkg::fn_and:  result = a & b;
          mips_pkg::fn_or:   result = a | b;
          mips_pkg::fn_xor:  result = a ^ b;
          mips_pkg::fn_nor:  result = ~(a | b);
          mips_pkg::fn_slt:  result = {31'd0, $signed(a) < $signed(b)};
          mips_pkg::fn_sltu: result = {31'd0, a < b};
          default:           result = 32'd0;  // jumps and hi/lo moves
        endcase
      end
      mips_pkg::alu_itype: begin
        case (opcode)
          mips_pkg::op_addiu: result = a + b;
          mips_pkg::op_slti:  result = {31'd0, $signed(a) < $signed(b)};
          mips_pkg::op_sltiu: result = {31'd0, a < b};  // imm sign extended, compared unsigned
          mips_pkg::op_andi:  result = a & b;
          mips_pkg::op_ori:   result = a | b;
          mips_pkg::op_xori:  result = a ^ b;
          mips_pkg::op_lui:   result = {b[15:0], 16'd0};
          default:            result = 32'd0;
        endcase
      end
      default: result = 32'd0;
    endcase
  end

  assign zero = (result == 32'd0);  // beq/bne compare

endmodule

`default_nettype wire

//--- source/hi_lo_unit.sv
// hi and lo registers of the cpu, loaded by mult/multu products or by mthi and mtlo
`timescale 1ns/1ps
`default_nettype none

module hi_lo_unit (
  input  logic        clk,
  input  logic        reset,
  input  logic        hi_wren,
  input  logic        lo_wren,
  input  logic        multdiv,      // load the product into both halves
  input  logic        signed_mult,  // mult rather than multu
  input  logic [31:0] a,            // rs, also the mthi/mtlo source
  input  logic [31:0] b,            // rt
  output logic [31:0] hi,
  output logic [31:0] lo
);

  logic [63:0] a_ext, b_ext, product;

  // low 64 bits of the extended product give the signed or unsigned result
  assign a_ext   = {{32{signed_mult & a[31]}}, a};
  assign b_ext   = {{32{signed_mult & b[31]}}, b};
  assign product = a_ext * b_ext;

  always_ff @(posedge clk) begin
    if (reset) begin
      hi <= 32'd0;
      lo <= 32'd0;
    end else if (multdiv) begin
      hi <= product[63:32];
      lo <= product[31:0];
    end else begin
      if (hi_wren) hi <= a;  // mthi
      if (lo_wren) lo <= a;  // mtlo
    end
  end

  // decode must pair a multiply with both enables
  a_mult_wren: assert property (@(posedge clk) disable iff (reset)
    multdiv |-> (hi_wren && lo_wren))
    else $error("hi_lo_unit: multiply without both write enables");

endmodule

`default_nettype wire

//--- source/mips_cpu_bus.sv
// top of the multicycle mips cpu: fsm, pc and datapath glue on one avalon-style memory bus
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus (
  input  logic        clk,
  input  logic        reset,
  output logic        active,       // low once pc reaches 0
  output logic [31:0] register_v0,
  output logic [31:0] address,      // word aligned byte address
  output logic        write,
  output logic        read,
  input  logic        waitrequest,
  output logic [31:0] writedata,
  output logic [3:0]  byteenable,
  input  logic [31:0] readdata
);

  mips_pkg::cpu_state_t state;
  mips_pkg::alu_op_t    alu_op;
  logic [31:0] pc, ir, mdr;         // mdr holds the load word until exec
  logic [5:0]  opcode, funct;
  logic [4:0]  rs, rt, rd, shamt, write_reg;
  logic [15:0] imm;
  logic        ctrl_read, ctrl_write, reg_write_enable, link_to_reg, mfhi, mflo;
  logic        hi_wren, lo_wren, multdiv, imdt_sel, alu_src, branch, jump, jumpreg;
  logic [2:0]  write_data_sel, datamem_to_reg;
  logic [1:0]  rd_select;
  logic [31:0] read_data_a, read_data_b, imm_ext, alu_b, alu_result, hi, lo;
  logic [31:0] pc_plus4, next_pc, load_ext, reg_wdata;
  logic [7:0]  load_byte;
  logic [15:0] load_half;
  logic        zero, taken;

  assign opcode = ir[31:26];
  assign rs     = ir[25:21];
  assign rt     = ir[20:16];  // also the regimm b code
  assign rd     = ir[15:11];
  assign shamt  = ir[10:6];
  assign funct  = ir[5:0];
  assign imm    = ir[15:0];

  control u_control (
    .reset, .opcode, .function_code(funct), .b_code(rt), .state,
    .byte_addressing(alu_result[1:0]), .read(ctrl_read), .write(ctrl_write),
    .write_data_sel, .byteenable, .rd_select, .reg_write_enable, .datamem_to_reg,
    .link_to_reg, .mfhi, .mflo, .hi_wren, .lo_wren, .multdiv, .imdt_sel, .alu_src,
    .alu_op, .branch, .jump, .jumpreg
  );

  register_file u_register_file (
    .clk, .reset, .read_reg_a(rs), .read_reg_b(rt), .write_reg,
    .write_data(reg_wdata), .write_enable(reg_write_enable),
    .read_data_a, .read_data_b, .register_v0
  );

  assign imm_ext = imdt_sel ? {16'd0, imm} : {{16{imm[15]}}, imm};
  assign alu_b   = alu_src ? imm_ext : read_data_b;

  alu u_alu (
    .alu_op, .function_code(funct), .opcode, .shamt,
    .a(read_data_a), .b(alu_b), .result(alu_result), .zero
  );

  hi_lo_unit u_hi_lo_unit (
    .clk, .reset, .hi_wren, .lo_wren, .multdiv,
    .signed_mult(funct == mips_pkg::fn_mult), .a(read_data_a), .b(read_data_b), .hi, .lo
  );

  // bus side; a halted cpu sits in fetch with read dropped
  assign read    = ctrl_read & active;
  assign write   = ctrl_write;
  assign address = (state == mips_pkg::st_mem) ? {alu_result[31:2], 2'b00} : pc;

  always_comb begin
    case (write_data_sel)  // rt placed on the enabled lanes
      3'd1:    writedata = {24'd0, read_data_b[7:0]};
      3'd2:    writedata = {16'd0, read_data_b[7:0], 8'd0};
      3'd3:    writedata = {8'd0, read_data_b[7:0], 16'd0};
      3'd4:    writedata = {read_data_b[7:0], 24'd0};
      3'd5:    writedata = {16'd0, read_data_b[15:0]};
      3'd6:    writedata = {read_data_b[15:0], 16'd0};
      default: writedata = read_data_b;
    endcase
  end

  // little endian lanes, address recomputed by the alu in exec
  assign load_byte = mdr[{alu_result[1:0], 3'b000} +: 8];
  assign load_half = alu_result[1] ? mdr[31:16] : mdr[15:0];

  always_comb begin
    case (datamem_to_reg)
      3'd2:    load_ext = {{24{load_byte[7]}}, load_byte};
      3'd3:    load_ext = {24'd0, load_byte};
      3'd4:    load_ext = {{16{load_half[15]}}, load_half};
      3'd5:    load_ext = {16'd0, load_half};
      default: load_ext = mdr;  // lw
    endcase
  end

  assign reg_wdata = link_to_reg ? pc_plus4 :
                     mfhi ? hi :
                     mflo ? lo :
                     (datamem_to_reg != 3'd0) ? load_ext : alu_result;

  always_comb begin
    case (rd_select)
      2'd1:    write_reg = rd;
      2'd2:    write_reg = mips_pkg::link_reg;
      default: write_reg = rt;
    endcase
  end

  always_comb begin
    taken = 1'b0;
    case (opcode)
      mips_pkg::op_beq:  taken = zero;
      mips_pkg::op_bne:  taken = !zero;
      mips_pkg::op_blez: taken = read_data_a[31] || (read_data_a == 32'd0);
      mips_pkg::op_bgtz: taken = !read_data_a[31] && (read_data_a != 32'd0);
      mips_pkg::op_regimm: begin
        case (rt)
          mips_pkg::rt_bltz, mips_pkg::rt_bltzal: taken = read_data_a[31];
          mips_pkg::rt_bgez, mips_pkg::rt_bgezal: taken = !read_data_a[31];
          default: taken = 1'b0;
        endcase
      end
      default: taken = 1'b0;
    endcase
  end

  // no delay slot, redirect applies to the very next fetch
  assign pc_plus4 = pc + 32'd4;
  always_comb begin
    if (jumpreg)
      next_pc = read_data_a;
    else if (jump)
      next_pc = {pc_plus4[31:28], ir[25:0], 2'b00};
    else if (branch && taken)
      next_pc = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    else
      next_pc = pc_plus4;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= mips_pkg::st_fetch;
      pc     <= mips_pkg::reset_vector;
      active <= 1'b1;
    end else begin
      case (state)
        mips_pkg::st_fetch: if (active && !waitrequest) state <= mips_pkg::st_load;
        mips_pkg::st_load:  state <= mips_pkg::st_mem;
        mips_pkg::st_mem: begin
          if (!((ctrl_read || ctrl_write) && waitrequest)) state <= mips_pkg::st_exec;
        end
        mips_pkg::st_exec: begin
          pc    <= next_pc;
          state <= mips_pkg::st_fetch;
          if (next_pc == 32'd0) active <= 1'b0;  // halt
        end
        default: state <= mips_pkg::st_fetch;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == mips_pkg::st_fetch && read && !waitrequest) ir <= readdata;
    if (state == mips_pkg::st_mem && read && !waitrequest) mdr <= readdata;
  end

  // stalled transfers keep every request signal until accepted
  a_bus_hold: assert property (@(posedge clk) disable iff (reset)
    (read || write) && waitrequest |=>
      $stable(address) && $stable(read) && $stable(write) &&
      $stable(writedata) && $stable(byteenable))
    else $error("mips_cpu_bus: bus outputs changed under waitrequest");

endmodule

`default_nettype wire

//--- tb/bus_memory_model.sv
// word memory for the cpu testbench: code and data regions share one array, random waitrequest stalls
`timescale 1ns/1ps
`default_nettype none

module bus_memory_model (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] address,
  input  logic        read,
  input  logic        write,
  input  logic [31:0] writedata,
  input  logic [3:0]  byteenable,
  input  logic [31:0] image [256],  // contents copied in while reset is high
  output logic [31:0] readdata,
  output logic        waitrequest
);

  logic [31:0] mem [256];
  logic [1:0]  stall_run;  // consecutive stall cycles so far
  integer      seed;

  // code at the reset vector in 0..127, data from 0x1000 in 128..255
  function automatic logic [7:0] word_index(input logic [31:0] addr);
    return addr[31] ? {1'b0, addr[8:2]} : {1'b1, addr[8:2]};
  endfunction

  assign readdata = read ? mem[word_index(address)] : 32'h0;

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= image[i];
      end
    end else if (write && !waitrequest) begin
      for (int l = 0; l < 4; l++) begin
        if (byteenable[l]) mem[word_index(address)][l*8 +: 8] <= writedata[l*8 +: 8];
      end
    end
  end

  // one stall in four, never more than three in a row
  initial begin
    seed        = 32'h0c30249e;
    waitrequest = 1'b0;
    stall_run   = 2'd0;
    forever begin
      @(negedge clk);
      waitrequest = (($random(seed) & 3) == 0) && (stall_run != 2'd3);
      stall_run   = waitrequest ? stall_run + 2'd1 : 2'd0;
    end
  end

endmodule

`default_nettype wire

//--- tb/mips_cpu_bus_tb.sv
// testbench that runs a built-in program on the multicycle mips cpu and its bus model and checks the results
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_tb;

  logic        clk, reset, active, write, read, waitrequest;
  logic [31:0] register_v0, address, writedata, readdata;
  logic [3:0]  byteenable;
  logic [31:0] image [256];
  logic [31:0] cur_instr;   // last word fetched from the code region
  int          prog_len;
  int          errors;

  mips_cpu_bus u_mips_cpu_bus (
    .clk, .reset, .active, .register_v0, .address, .write, .read,
    .waitrequest, .writedata, .byteenable, .readdata
  );

  bus_memory_model u_memory (
    .clk, .reset, .address, .read, .write, .writedata, .byteenable,
    .image, .readdata, .waitrequest
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] shamt);
    return {6'd0, rs, rt, rd, shamt, funct};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] target);
    return {op, target[27:2]};
  endfunction

  function automatic logic [31:0] code_addr(input int idx);
    return mips_pkg::reset_vector + 32'(idx * 4);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;  // every address bit matters
  endfunction

  // data bases in the program are word aligned, so imm[1:0] are the address low bits
  function automatic logic [3:0] expected_be(input logic [31:0] instr);
    case (instr[31:26])
      mips_pkg::op_sb: return 4'b0001 << instr[1:0];
      mips_pkg::op_sh: return instr[1] ? 4'b1100 : 4'b0011;
      mips_pkg::op_sw: return 4'b1111;
      default:         return 4'b0000;  // no store in flight
    endcase
  endfunction

  function automatic logic [31:0] expected_v0();
    logic [31:0] r8, r9, r10, r11, r12, r13, a, b, v;
    logic [63:0] sp, up;
    r8  = 32'h0000_1234;
    r9  = 32'h0000_8001;
    r10 = 32'h00f0_0000;
    r11 = r10 - r8;
    r12 = ($signed(r11) < $signed(r10)) ? 32'd1 : 32'd0;
    r13 = r9 << 4;
    v   = r11 + r13 + r12;
    // lb, lbu, lh, lhu of the stored 0x85f3 bytes, then lw of word 0
    v = v + 32'hffff_fff3 + 32'h0000_00f3 + 32'hffff_85f3 + 32'h0000_85f3 + 32'h00f0_f300;
    v = v + 32'd1;                                        // untaken bne path
    v = v + code_addr(28) + 32'd4 + code_addr(31) + 32'd4; // bltzal, bgezal links
    v = v + code_addr(33) + 32'd4 + code_addr(38) + 32'd4; // jal, jalr links
    a  = 32'hffff_fffd;
    b  = 32'h7654_3210;
    sp = longint'(signed'(a)) * longint'(signed'(b));
    up = 64'(a) * 64'(b);
    v  = v + sp[63:32] + sp[31:0] + up[63:32] + up[31:0] + r8;  // last term via mthi
    return v;
  endfunction

  task automatic place(input logic [31:0] word);
    image[prog_len] = word;
    prog_len++;
  endtask

  task automatic build_image();
    for (int i = 0; i < 128; i++) begin
      image[i]       = fill_word(code_addr(i));
      image[128 + i] = fill_word(32'h0000_1000 + 32'(i * 4));
    end
    prog_len = 0;
    place(enc_i(mips_pkg::op_addiu, 0, 8, 16'h1234));        // 0
    place(enc_i(mips_pkg::op_ori, 0, 9, 16'h8001));
    place(enc_i(mips_pkg::op_lui, 0, 10, 16'h00f0));
    place(enc_r(mips_pkg::fn_subu, 10, 8, 11, 0));
    place(enc_r(mips_pkg::fn_slt, 11, 10, 12, 0));
    place(enc_r(mips_pkg::fn_sll, 0, 9, 13, 4));
    place(enc_r(mips_pkg::fn_addu, 11, 13, 2, 0));
    place(enc_r(mips_pkg::fn_addu, 2, 12, 2, 0));
    place(enc_i(mips_pkg::op_addiu, 0, 14, 16'h1000));       // 8 data base
    place(enc_i(mips_pkg::op_ori, 0, 15, 16'h85f3));
    place(enc_i(mips_pkg::op_sw, 14, 10, 16'd0));
    place(enc_i(mips_pkg::op_sb, 14, 15, 16'd1));
    place(enc_i(mips_pkg::op_sh, 14, 15, 16'd6));
    place(enc_i(mips_pkg::op_sb, 14, 15, 16'd4));
    place(enc_i(mips_pkg::op_lb, 14, 16, 16'd1));            // 14
    place(enc_i(mips_pkg::op_lbu, 14, 17, 16'd1));
    place(enc_i(mips_pkg::op_lh, 14, 18, 16'd6));
    place(enc_i(mips_pkg::op_lhu, 14, 19, 16'd6));
    place(enc_i(mips_pkg::op_lw, 14, 20, 16'd0));
    for (int r = 16; r <= 20; r++) begin
      place(enc_r(mips_pkg::fn_addu, 2, 5'(r), 2, 0));       // 19..23
    end
    place(enc_i(mips_pkg::op_beq, 8, 8, 16'd1));             // 24 taken
    place(enc_i(mips_pkg::op_addiu, 2, 2, 16'h0100));        // skipped
    place(enc_i(mips_pkg::op_bne, 8, 8, 16'd1));             // 26 falls through
    place(enc_i(mips_pkg::op_addiu, 2, 2, 16'd1));
    place(enc_i(mips_pkg::op_regimm, 16, mips_pkg::rt_bltzal, 16'd1));  // 28 taken
    place(enc_i(mips_pkg::op_addiu, 2, 2, 16'h0200));        // skipped
    place(enc_r(mips_pkg::fn_addu, 2, 31, 2, 0));
    place(enc_i(mips_pkg::op_regimm, 16, mips_pkg::rt_bgezal, 16'd1));  // 31 not taken
    place(enc_r(mips_pkg::fn_addu, 2, 31, 2, 0));
    place(enc_j(mips_pkg::op_jal, code_addr(35)));           // 33
    place(enc_i(mips_pkg::op_addiu, 2, 2, 16'h0300));        // skipped
    place(enc_r(mips_pkg::fn_addu, 2, 31, 2, 0));
    place(enc_i(mips_pkg::op_lui, 0, 21, 16'hbfc0));         // 36
    place(enc_i(mips_pkg::op_ori, 21, 21, 16'h00a0));        // r21 = address of 40
    place(enc_r(mips_pkg::fn_jalr, 21, 0, 22, 0));           // 38
    place(enc_i(mips_pkg::op_addiu, 2, 2, 16'h0400));        // skipped
    place(enc_r(mips_pkg::fn_addu, 2, 22, 2, 0));
    place(enc_i(mips_pkg::op_addiu, 0, 23, 16'hfffd));       // 41
    place(enc_i(mips_pkg::op_lui, 0, 24, 16'h7654));
    place(enc_i(mips_pkg::op_ori, 24, 24, 16'h3210));
    place(enc_r(mips_pkg::fn_mult, 23, 24, 0, 0));
    place(enc_r(mips_pkg::fn_mfhi, 0, 0, 25, 0));
    place(enc_r(mips_pkg::fn_mflo, 0, 0, 26, 0));
    place(enc_r(mips_pkg::fn_addu, 2, 25, 2, 0));
    place(enc_r(mips_pkg::fn_addu, 2, 26, 2, 0));
    place(enc_r(mips_pkg::fn_multu, 23, 24, 0, 0));          // 49
    place(enc_r(mips_pkg::fn_mfhi, 0, 0, 25, 0));
    place(enc_r(mips_pkg::fn_mflo, 0, 0, 26, 0));
    place(enc_r(mips_pkg::fn_addu, 2, 25, 2, 0));
    place(enc_r(mips_pkg::fn_addu, 2, 26, 2, 0));
    place(enc_r(mips_pkg::fn_mthi, 8, 0, 0, 0));             // 54
    place(enc_r(mips_pkg::fn_mfhi, 0, 0, 27, 0));
    place(enc_r(mips_pkg::fn_addu, 2, 27, 2, 0));
    place(enc_i(mips_pkg::op_addiu, 0, 0, 16'h0055));        // 57 aimed at r0, must be dropped
    place(enc_r(mips_pkg::fn_jr, 0, 0, 0, 0));               // 58 halt only if r0 stayed 0
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors = errors + 1;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    if (read && !waitrequest && address[31]) cur_instr <= readdata;
  end

  a_no_dual: assert property (@(posedge clk) !(read && write))
    else begin
      errors = errors + 1;
      $display("bus drove read and write in the same cycle");
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (reset)
    (read || write) && waitrequest |=>
      $stable(address) && $stable(read) && $stable(write) &&
      $stable(writedata) && $stable(byteenable))
    else begin
      errors = errors + 1;
      $display("bus outputs moved while waitrequest was high");
    end

  a_reset_write: assert property (@(posedge clk) reset |-> !write)
    else begin
      errors = errors + 1;
      $display("write went high during reset");
    end

  a_lanes: assert property (@(posedge clk) disable iff (reset)
    write |-> byteenable == expected_be(cur_instr))
    else begin
      errors = errors + 1;
      $display("CHECK FAILED byteenable got %h expected %h",
               $sampled(byteenable), expected_be($sampled(cur_instr)));
    end

  a_halt_idle: assert property (@(posedge clk) disable iff (reset) !active |-> !read)
    else begin
      errors = errors + 1;
      $display("read went high after the cpu halted");
    end

  // worst case is 4 cycles per instruction stretched by up to 3 stalls per bus phase
  initial begin
    int unsigned timeout_cycles;
    @(negedge reset);
    timeout_cycles = 4 * prog_len * 3 + 100;
    repeat (timeout_cycles) @(posedge clk);
    $display("watchdog expired before the cpu halted, errors %0d", errors + 1);
    $display("tests failed");
    $finish;
  end

  initial begin
    errors    = 0;
    cur_instr = 32'h0;
    reset     = 1'b1;
    build_image();
    repeat (2) @(negedge clk);
    reset = 1'b0;
    while (active) @(negedge clk);
    repeat (8) @(negedge clk);  // halted cpu must keep read low
    check_word("register_v0", register_v0, expected_v0());
    check_word("data word 0", u_memory.mem[128], 32'h00f0_f300);
    check_word("data word 1", u_memory.mem[129],
               32'h85f3_00f3 | (fill_word(32'h0000_1004) & 32'h0000_ff00));
    check_word("active", {31'd0, active}, 32'd0);
    $display("errors %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
source/mips_pkg.sv
source/control.sv
source/register_file.sv
source/alu.sv
source/hi_lo_unit.sv
source/mips_cpu_bus.sv
tb/bus_memory_model.sv
tb/mips_cpu_bus_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert --timing -j 0
TOP       = mips_cpu_bus_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
